/* design/pow_cfg.svh */
`ifndef POW_CFG_SVH
`define POW_CFG_SVH

// Operand width, every power is kept modulo 2 to this power.
`define POW_W      8

// Number of pipeline stages, one per power from 1 to 5.
`define POW_STAGES 5

// Width of the register write address.
`define POW_ADDR_W 2

`endif

/* design/pow_data_pkg.sv */
`include "pow_cfg.svh"
`default_nettype none

package pow_data_pkg;

    // One unsigned operand or partial power.
    typedef logic [`POW_W-1:0] operand_t;

    // Element 4 is the first power and element 0 the fifth.
    typedef operand_t [`POW_STAGES-1:0] res_vec_t;

    // Valid bits, indexed like res_vec_t.
    typedef logic [`POW_STAGES-1:0] vld_vec_t;

endpackage

`default_nettype wire

/* design/pow_ctrl_pkg.sv */
`include "pow_cfg.svh"
`default_nettype none

package pow_ctrl_pkg;

    // Register map of the write port.
    typedef enum logic [`POW_ADDR_W-1:0] {
        ADDR_CTRL = `POW_ADDR_W'd0, // bit 0 of the data is the run bit.
        ADDR_STEP = `POW_ADDR_W'd1, // any write gives one enabled cycle.
        ADDR_CLR  = `POW_ADDR_W'd2  // any write clears the accumulator.
    } reg_addr_e;

    // Control register, run sits in bit 0.
    typedef struct packed {
        logic [6:0] rsvd; // reads back as zero.
        logic       run;
    } ctrl_reg_t;

endpackage

`default_nettype wire

/* design/pow_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pow_cfg_regs
    import pow_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  reg_addr_e  wr_addr,
    input  logic [7:0] wr_data,
    output logic       clk_en,
    output logic       acc_clr,
    output logic       run
);

    ctrl_reg_t ctrl_q;  // control register.
    logic      step_q;  // one-cycle step pulse.
    logic      clr_q;   // one-cycle clear pulse.

    logic      wr_ctrl;
    logic      wr_step;
    logic      wr_clr;

    // Address decode of the write strobe.
    assign wr_ctrl = wr_en && (wr_addr == ADDR_CTRL);
    assign wr_step = wr_en && (wr_addr == ADDR_STEP);
    assign wr_clr  = wr_en && (wr_addr == ADDR_CLR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (wr_ctrl) begin
            ctrl_q <= '{rsvd: '0, run: wr_data[0]}; // reserved bits are not stored.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= 1'b0;
        end else begin
            step_q <= wr_step; // high for the cycle after the write.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_q <= 1'b0;
        end else begin
            clr_q <= wr_clr; // high for the cycle after the write.
        end
    end

    assign run     = ctrl_q.run;
    assign clk_en  = ctrl_q.run | step_q; // free running or a single step.
    assign acc_clr = clr_q;

    // The accumulator sees each clear as a single pulse.
    a_clr_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_clr |=> !acc_clr
    ) else $error("acc_clr stayed high for two cycles.");

endmodule

`default_nettype wire

/* design/pow_5_en_pipe.sv */
`timescale 1ns/1ps
`include "pow_cfg.svh"
`default_nettype none

module pow_5_en_pipe
    import pow_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clk_en,
    input  logic     arg_vld,
    input  operand_t arg,
    output vld_vec_t res_vld,
    output res_vec_t res
);

    // Valid bits in output order, bit 4 is stage 1 and bit 0 stage 5.
    vld_vec_t vld_q;

    // Operand copies travel with the data through stages 1 to 4.
    // Stage 5 has no successor, so the operand is not carried there.
    operand_t opnd_q [1:`POW_STAGES-1];

    // Partial powers of stages 2 to 5. Stage 1 shows the operand itself.
    operand_t pow_q  [2:`POW_STAGES];

    // Valid shift register, the only flops with a reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (clk_en) begin
            vld_q <= {arg_vld, vld_q[`POW_STAGES-1:1]}; // new operand enters at stage 1.
        end
    end

    // Datapath flops, frozen together with the valid bits.
    always_ff @(posedge clk) begin
        if (clk_en) begin
            opnd_q[1] <= arg;
            pow_q[2]  <= opnd_q[1] * opnd_q[1];

            for (int k = 2; k < `POW_STAGES; k++) begin
                opnd_q[k] <= opnd_q[k-1];
            end

            // Each stage multiplies by the operand once more and keeps the low w bits.
            for (int k = 3; k <= `POW_STAGES; k++) begin
                pow_q[k] <= pow_q[k-1] * opnd_q[k-1];
            end
        end
    end

    assign res_vld = vld_q;

    // Stage k appears at element POW_STAGES - k.
    always_comb begin
        res[`POW_STAGES-1] = opnd_q[1];
        for (int k = 2; k <= `POW_STAGES; k++) begin
            res[`POW_STAGES-k] = pow_q[k];
        end
    end

    a_vld_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(res_vld)
    ) else $error("res_vld has unknown bits after reset.");

    // A frozen pipeline must not lose or create results.
    a_vld_frozen : assert property (
        @(posedge clk) disable iff (!rst_n)
        !clk_en |=> $stable(res_vld)
    ) else $error("res_vld changed while clk_en was low.");

endmodule

`default_nettype wire

/* design/pow_result_acc.sv */
`timescale 1ns/1ps
`default_nettype none

module pow_result_acc
    import pow_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_en,
    input  logic        acc_clr,
    input  logic        fin_vld,
    input  operand_t    fin,
    output logic [15:0] result_count,
    output operand_t    checksum
);

    logic     [15:0] count_q;
    operand_t        sum_q;

    always_ff @(posedge clk) begin
        if (!rst_n || acc_clr) begin
            count_q <= '0; // a clear wins over a result in the same cycle.
            sum_q   <= '0;
        end else if (clk_en && fin_vld) begin
            count_q <= count_q + 16'd1;
            sum_q   <= sum_q + fin; // wraps modulo 2 to the operand width.
        end
    end

    assign result_count = count_q;
    assign checksum     = sum_q;

    // Only a clear may move the count backwards, apart from a 16-bit wrap.
    a_count_mono : assert property (
        @(posedge clk) disable iff (!rst_n)
        !acc_clr |=> (result_count >= $past(result_count)) ||
                     ($past(result_count) == 16'hffff)
    ) else $error("result_count decreased without a clear.");

endmodule

`default_nettype wire

/* design/pow_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pow_top
    import pow_data_pkg::*, pow_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  reg_addr_e   wr_addr,
    input  logic [7:0]  wr_data,
    input  logic        arg_vld,
    input  operand_t    arg,
    output vld_vec_t    res_vld,
    output res_vec_t    res,
    output logic [15:0] result_count,
    output operand_t    checksum,
    output logic        clk_en
);

    logic acc_clr; // one-cycle clear from the register block.

    pow_cfg_regs i_cfg_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .clk_en  (clk_en),
        .acc_clr (acc_clr),
        .run     ()          // run is already visible through clk_en.
    );

    pow_5_en_pipe i_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .clk_en  (clk_en),
        .arg_vld (arg_vld),
        .arg     (arg),
        .res_vld (res_vld),
        .res     (res)
    );

    // The accumulator taps the fifth-power stage.
    pow_result_acc i_acc (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_en       (clk_en),
        .acc_clr      (acc_clr),
        .fin_vld      (res_vld[0]),
        .fin          (res[0]),
        .result_count (result_count),
        .checksum     (checksum)
    );

endmodule

`default_nettype wire

/* verification/pow_checker.sv */
`timescale 1ns/1ps
`include "pow_cfg.svh"
`default_nettype none

module pow_checker
    import pow_data_pkg::*, pow_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  reg_addr_e       wr_addr,
    input  logic [7:0]      wr_data,
    input  logic            arg_vld,
    input  operand_t        arg,
    input  logic            clk_en,
    input  vld_vec_t        res_vld,
    input  res_vec_t        res,
    input  logic [15:0]     result_count,
    input  operand_t        checksum,
    input  logic            test_start,
    input  logic [8*16-1:0] test_name,
    input  logic            exp_req,
    input  operand_t        exp_sum,
    input  logic [15:0]     exp_cnt,
    input  logic            run_done,
    output int              pass_cnt,
    output int              fail_cnt
);

    logic     run_m;                     // expected run bit.
    logic     step_m;                    // expected step pulse.
    vld_vec_t vld_m;                     // expected valid bits.
    operand_t opnd_m [1:`POW_STAGES];    // operand held at each stage.
    int       test_errs;

    // x to the power k, kept to the operand width.
    function automatic operand_t power_of(input operand_t x, input int k);
        operand_t p;
        p = 1;
        for (int i = 0; i < k; i++) begin
            p = p * x;
        end
        return p;
    endfunction

    task automatic report_value(input string what, input logic [15:0] exp,
                                input logic [15:0] act);
        $display("** Error test %0s: %0s expected %h actual %h", test_name, what, exp, act);
        test_errs++;
    endtask

    // Reference behavior taken from the register map and the stage timing.
    always @(posedge clk) begin
        if (!rst_n) begin
            run_m  <= 1'b0;
            step_m <= 1'b0;
            vld_m  <= '0;
        end else begin
            if (run_m || step_m) begin
                vld_m     <= {arg_vld, vld_m[`POW_STAGES-1:1]}; // stage 1 is the top bit.
                opnd_m[1] <= arg;
                for (int k = 2; k <= `POW_STAGES; k++) begin
                    opnd_m[k] <= opnd_m[k-1];
                end
            end
            step_m <= wr_en && (wr_addr == ADDR_STEP);
            if (wr_en && (wr_addr == ADDR_CTRL)) begin
                run_m <= wr_data[0];
            end
        end
    end

    // Outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (!rst_n) begin
            pass_cnt  = 0;
            fail_cnt  = 0;
            test_errs = 0;
        end else begin
            if (test_start) begin
                if (test_errs != 0) begin
                    fail_cnt++;
                    $display("checker: %0d errors found before test %0s started",
                             test_errs, test_name);
                end
                test_errs = 0;
            end
            if (clk_en !== (run_m | step_m)) begin
                report_value("clk_en", run_m | step_m, clk_en);
            end
            if (res_vld !== vld_m) begin
                report_value("res_vld", vld_m, res_vld);
            end
            for (int k = 1; k <= `POW_STAGES; k++) begin
                if (vld_m[`POW_STAGES-k] &&
                    (res[`POW_STAGES-k] !== power_of(opnd_m[k], k))) begin
                    report_value($sformatf("res of stage %0d", k),
                                 power_of(opnd_m[k], k), res[`POW_STAGES-k]);
                end
            end
            if (exp_req) begin
                if (checksum !== exp_sum) begin
                    report_value("checksum", exp_sum, checksum);
                end
                if (result_count !== exp_cnt) begin
                    report_value("result_count", exp_cnt, result_count);
                end
                if (test_errs == 0) begin
                    pass_cnt++;
                    $display("test %0s: passed", test_name);
                end else begin
                    fail_cnt++;
                    $display("test %0s: failed with %0d errors", test_name, test_errs);
                end
                test_errs = 0;
            end
            if (run_done) begin
                if (test_errs != 0) begin
                    fail_cnt++;
                    $display("checker: %0d errors found after the last test", test_errs);
                end
                $display("checker: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
            end
        end
    end

endmodule

`default_nettype wire

/* verification/pow_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pow_tb
    import pow_data_pkg::*, pow_ctrl_pkg::*;
();

    localparam int unsigned SEED       = 32'h5067_f054;
    localparam int          RST_CYCLES = 16;

    logic            clk;
    logic            rst_n;
    logic            wr_en;
    reg_addr_e       wr_addr;
    logic [7:0]      wr_data;
    logic            arg_vld;
    operand_t        arg;
    vld_vec_t        res_vld;
    res_vec_t        res;
    logic [15:0]     result_count;
    operand_t        checksum;
    logic            clk_en;

    logic            test_start;
    logic [8*16-1:0] test_name;
    logic            exp_req;
    operand_t        exp_sum;
    logic [15:0]     exp_cnt;
    logic            run_done;
    int              pass_cnt;
    int              fail_cnt;

    logic [7:0]      cmd_q  [$];   // one entry per trace command.
    logic [8*16-1:0] name_q [$];
    logic [15:0]     a_q    [$];
    logic [15:0]     b_q    [$];
    int              trace_len;
    logic            load_ok;
    logic            wd_armed;
    int unsigned     rnd;

    pow_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .arg_vld      (arg_vld),
        .arg          (arg),
        .res_vld      (res_vld),
        .res          (res),
        .result_count (result_count),
        .checksum     (checksum),
        .clk_en       (clk_en)
    );

    pow_checker chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .arg_vld      (arg_vld),
        .arg          (arg),
        .clk_en       (clk_en),
        .res_vld      (res_vld),
        .res          (res),
        .result_count (result_count),
        .checksum     (checksum),
        .test_start   (test_start),
        .test_name    (test_name),
        .exp_req      (exp_req),
        .exp_sum      (exp_sum),
        .exp_cnt      (exp_cnt),
        .run_done     (run_done),
        .pass_cnt     (pass_cnt),
        .fail_cnt     (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    task automatic load_trace();
        int              fd;
        int              code;
        logic [7:0]      c;
        logic [8*120-1:0] rest;
        logic [8*16-1:0] nm;
        logic [15:0]     x;
        logic [15:0]     y;
        fd = $fopen("verification/pow_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verification/pow_trace.txt");
            load_ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                c    = 8'd0;
                nm   = '0;
                x    = '0;
                y    = '0;
                code = $fscanf(fd, " %c", c);
                if (code == 1) begin
                    case (c)
                        "#": code = $fgets(rest, fd); // comment line.
                        "t": code = $fscanf(fd, "%s", nm);
                        "e": code = $fscanf(fd, "%s %h %h", nm, x, y);
                        "w": code = $fscanf(fd, "%h %h", x, y);
                        "a", "i": code = $fscanf(fd, "%h", x);
                        default: begin
                            $display("unknown trace command '%c'", c);
                            load_ok = 1'b0;
                        end
                    endcase
                    if (c != "#") begin
                        cmd_q.push_back(c);
                        name_q.push_back(nm);
                        a_q.push_back(x);
                        b_q.push_back(y);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs change 1 ns after the rising edge, pulses last one cycle.
    task automatic next_cycle();
        @(posedge clk);
        #1;
        wr_en      = 1'b0;
        arg_vld    = 1'b0;
        test_start = 1'b0;
        exp_req    = 1'b0;
    endtask

    task automatic run_command(input int n);
        int gap;
        gap = 0;
        case (cmd_q[n])
            "t": begin
                gap = $urandom_range(3, 0); // random idle cycles between tests.
                repeat (gap) next_cycle();
                next_cycle();
                test_name  = name_q[n];
                test_start = 1'b1;
            end
            "w": begin
                next_cycle();
                wr_en   = 1'b1;
                wr_addr = reg_addr_e'(a_q[n][1:0]);
                wr_data = b_q[n][7:0];
            end
            "a": begin
                next_cycle();
                arg_vld = 1'b1;
                arg     = a_q[n][7:0];
            end
            "i": begin
                repeat (a_q[n]) next_cycle();
            end
            default: begin
                next_cycle();
                test_name = name_q[n];
                exp_sum   = a_q[n][7:0];
                exp_cnt   = b_q[n];
                exp_req   = 1'b1;
            end
        endcase
    endtask

    initial begin
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = ADDR_CTRL;
        wr_data    = 8'h00;
        arg_vld    = 1'b0;
        arg        = '0;
        test_start = 1'b0;
        test_name  = "none";
        exp_req    = 1'b0;
        exp_sum    = '0;
        exp_cnt    = '0;
        run_done   = 1'b0;
        load_ok    = 1'b1;
        wd_armed   = 1'b0;
        rnd        = $urandom(SEED);
        load_trace();
        trace_len = cmd_q.size();
        wd_armed  = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < trace_len; n++) begin
            run_command(n);
        end
        next_cycle();
        run_done = 1'b1;
        next_cycle();
        run_done = 1'b0;
        if (!load_ok || fail_cnt != 0 || pass_cnt == 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

    // Budget of 20 cycles per trace command plus margin for reset.
    initial begin
        wait (wd_armed);
        repeat (trace_len * 20 + 200) @(posedge clk);
        $display("timeout: the trace did not finish within %0d cycles", trace_len * 20 + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
design/pow_data_pkg.sv
design/pow_ctrl_pkg.sv
design/pow_cfg_regs.sv
design/pow_5_en_pipe.sv
design/pow_result_acc.sv
design/pow_top.sv
verification/pow_checker.sv
verification/pow_tb.sv

/* verification/pow_trace.txt */
# t name | w addr data | a operand | i cycles | e name checksum count
# all numbers are hex, checksum is the sum of fifth powers modulo 256
t reset
i 2
e reset 00 0000
t run_b2b
w 0 01
a 02
a 03
a 05
a 07
i 8
e run_b2b ef 0004
t freeze
a 0b
a 0d
w 0 00
i a
e freeze ef 0004
t step
w 1 00
w 1 00
w 1 00
w 1 00
i 3
e step 67 0006
t clear
w 2 00
i 2
e clear 00 0000
t refill
w 0 01
a ff
a 10
a 81
i 8
e refill 80 0003
